// ==== test/rename_input.txt ====
// columns: instruction word, rs1_phys, rs2_phys, rd_phys, old_rd_phys
// one line per word at address 4 * line, rd_phys 00 means no destination
00500093 00 05 20 01
00700113 00 07 21 02
002081B3 20 21 22 03
001180B3 22 20 23 20
0011A023 22 23 00 00
00208033 23 21 00 00
00108213 23 23 24 04
00220463 24 21 00 00
123452B7 08 22 25 05
00428333 25 24 26 06
003181B3 22 22 27 22
00000013 00 00 00 00
003303B3 26 27 28 07
FFF08093 23 1F 29 23
0070A223 29 28 00 00
00138133 28 29 2A 21
010000EF 00 10 2B 29
00110433 2A 2B 2C 08
008404B3 2C 2C 2D 09
00348113 2D 27 2E 2A
00000063 00 00 00 00
009100B3 2E 2D 2F 2B

// ==== build.f ====
+incdir+hdl
hdl/rename_pkg.sv
hdl/rat_if.sv
hdl/sync_fifo.sv
hdl/wb_fetch.sv
hdl/rat.sv
hdl/rename_stage.sv
hdl/rename_top.sv
test/tb_clock.sv
test/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_frontend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rename_pkg.sv
      - hdl/rat_if.sv
      - hdl/sync_fifo.sv
      - hdl/wb_fetch.sv
      - hdl/rat.sv
      - hdl/rename_stage.sv
      - hdl/rename_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/rename_tb.sv

// ==== test/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb;
    localparam int MAX_LINES       = 64;
    localparam int COLS            = 5;
    localparam int FILL_CYCLES     = 32;
    localparam int CYCLES_PER_LINE = 20;

    logic        clk;
    logic        rst;
    logic [31:0] imem_adr;
    logic        imem_cyc;
    logic        imem_stb;
    logic [31:0] imem_rdata;
    logic        imem_ack;
    logic        ren_valid;
    logic        ren_ready;
    logic [31:0] ren_pc;
    logic [31:0] ren_instr;
    logic [5:0]  ren_rs1_phys;
    logic [5:0]  ren_rs2_phys;
    logic [5:0]  ren_rd_phys;
    logic [5:0]  ren_old_rd_phys;
    logic        ren_has_rd;
    logic        free_valid;
    logic [5:0]  free_preg;

    integer      seed;
    logic [31:0] stim [0:MAX_LINES*COLS-1];
    int          n_lines;
    int          accepted;
    int          cycles;
    int          limit;
    logic        done;
    // wishbone slave state
    int          wait_left;
    logic        bus_busy;
    // retire model, old mappings waiting to go back
    logic [5:0]  free_queue [$];
    // back-pressure tracking
    logic        stalled;
    logic [88:0] held_payload;

    tb_clock clock_gen_i (
        .clk(clk),
        .rst(rst)
    );

    rename_top dut_i (
        .clk(clk), .rst(rst),
        .imem_adr(imem_adr), .imem_cyc(imem_cyc), .imem_stb(imem_stb),
        .imem_rdata(imem_rdata), .imem_ack(imem_ack),
        .ren_valid(ren_valid), .ren_ready(ren_ready),
        .ren_pc(ren_pc), .ren_instr(ren_instr),
        .ren_rs1_phys(ren_rs1_phys), .ren_rs2_phys(ren_rs2_phys),
        .ren_rd_phys(ren_rd_phys), .ren_old_rd_phys(ren_old_rd_phys),
        .ren_has_rd(ren_has_rd),
        .free_valid(free_valid), .free_preg(free_preg)
    );

    // program word at a byte address, branch-opcode filler past the end
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < n_lines) begin
            return stim[(addr >> 2) * COLS];
        end
        return {addr[31:7] ^ addr[24:0], 7'b1100011};
    endfunction

    // whole output payload in one vector
    function automatic logic [88:0] current_payload();
        return {ren_pc, ren_instr, ren_rs1_phys, ren_rs2_phys,
                ren_rd_phys, ren_old_rd_phys, ren_has_rd};
    endfunction

    task automatic check_field(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", test_name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // compare one accepted instruction with its line of the file
    task automatic check_output(input int k);
        string       name;
        logic [31:0] exp_has_rd;
        name = $sformatf("line %0d", k);
        // rd column 00 marks an instruction with no destination
        exp_has_rd = (stim[k*COLS+3] != 0) ? 32'd1 : 32'd0;
        check_field({name, " pc"}, 32'(4 * k), ren_pc);
        check_field({name, " instr"}, stim[k*COLS], ren_instr);
        check_field({name, " rs1_phys"}, stim[k*COLS+1], 32'(ren_rs1_phys));
        check_field({name, " rs2_phys"}, stim[k*COLS+2], 32'(ren_rs2_phys));
        check_field({name, " rd_phys"}, stim[k*COLS+3], 32'(ren_rd_phys));
        check_field({name, " old_rd_phys"}, stim[k*COLS+4], 32'(ren_old_rd_phys));
        check_field({name, " has_rd"}, exp_has_rd, 32'(ren_has_rd));
    endtask

    // slave side, random wait states before each ack
    task automatic drive_bus();
        // stb only counts inside a cycle
        assert (imem_cyc || !imem_stb) else begin
            $display("imem_stb was raised while imem_cyc was low");
            $display("Testbench failed");
            $fatal(1, "stb outside cycle");
        end
        if (imem_ack) begin
            // handshake finished on the last edge
            imem_ack   = 1'b0;
            imem_rdata = '0;
            bus_busy   = 1'b0;
        end else if (imem_cyc && imem_stb) begin
            if (!bus_busy) begin
                bus_busy  = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                imem_ack   = 1'b1;
                imem_rdata = fetch_word(imem_adr);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    endtask

    // retire model, hands back old mappings in order after random delay
    task automatic drive_free();
        free_valid = 1'b0;
        if (free_queue.size() > 0 && ($random(seed) & 1)) begin
            free_valid = 1'b1;
            free_preg  = free_queue.pop_front();
        end
    endtask

    // all inputs change 1 ns after the edge, one process keeps the random order fixed
    // reset is sampled on the edge itself
    always @(posedge clk) begin
        if (!rst) begin
            #1;
            drive_bus();
            // ready about three cycles in four
            ren_ready = (($random(seed) & 3) != 0);
            drive_free();
        end
    end

    // sample mid-cycle, a transfer happens at the next edge
    always @(negedge clk) begin
        if (rst) begin
            // no request and no output while reset is held
            assert (!imem_cyc && !imem_stb && !ren_valid) else begin
                $display("imem_cyc, imem_stb or ren_valid was high during reset");
                $display("Testbench failed");
                $fatal(1, "active in reset");
            end
        end else if (!done) begin
            if (stalled) begin
                assert (ren_valid) else begin
                    $display("ren_valid dropped while the output was held by ren_ready");
                    $display("Testbench failed");
                    $fatal(1, "valid dropped");
                end
                assert (current_payload() === held_payload) else begin
                    $display("Error: stall hold payload expected %h actual %h",
                             held_payload, current_payload());
                    $display("Testbench failed");
                    $fatal(1, "payload moved");
                end
            end
            if (ren_valid && ren_ready) begin
                check_output(accepted);
                if (ren_has_rd) begin
                    free_queue.push_back(ren_old_rd_phys);
                end
                accepted = accepted + 1;
                if (accepted == n_lines) begin
                    done = 1'b1;
                end
            end
            stalled      = ren_valid && !ren_ready;
            held_payload = current_payload();
        end
    end

    initial begin
        imem_rdata = '0;
        imem_ack   = 1'b0;
        ren_ready  = 1'b0;
        free_valid = 1'b0;
        free_preg  = '0;
        seed       = 32'hb165_8f71;
        accepted   = 0;
        done       = 1'b0;
        wait_left  = 0;
        bus_busy   = 1'b0;
        stalled    = 1'b0;
        // unread entries stay unknown, which ends the line count
        for (int i = 0; i < MAX_LINES * COLS; i++) begin
            stim[i] = 'x;
        end
        $readmemh("test/rename_input.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && !$isunknown(stim[n_lines * COLS])) begin
            n_lines = n_lines + 1;
        end
        if (n_lines == 0) begin
            $display("no program lines could be read from test/rename_input.txt");
            $display("Testbench failed");
            $fatal(1, "empty program");
        end else begin
            limit = FILL_CYCLES + CYCLES_PER_LINE * n_lines;
            wait (rst === 1'b0);
            cycles = 0;
            while (!done && cycles < limit) begin
                @(posedge clk);
                cycles = cycles + 1;
            end
            if (done) begin
                $display("Testbench passed");
                $finish;
            end else begin
                $display("timeout after %0d cycles with %0d of %0d instructions renamed",
                         cycles, accepted, n_lines);
                $display("Testbench failed");
                $fatal(1, "timeout");
            end
        end
    end
endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    // free-running clock, 10 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset high for the first edges, dropped just after an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end
endmodule

// ==== hdl/rename_top.sv ====
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_top
    import rename_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    output logic [`RENAME_XLEN-1:0]   imem_adr,
    output logic                      imem_cyc,
    output logic                      imem_stb,
    input  logic [`RENAME_XLEN-1:0]   imem_rdata,
    input  logic                      imem_ack,
    output logic                      ren_valid,
    input  logic                      ren_ready,
    output logic [`RENAME_XLEN-1:0]   ren_pc,
    output logic [`RENAME_XLEN-1:0]   ren_instr,
    output logic [`RENAME_PREG_W-1:0] ren_rs1_phys,
    output logic [`RENAME_PREG_W-1:0] ren_rs2_phys,
    output logic [`RENAME_PREG_W-1:0] ren_rd_phys,
    output logic [`RENAME_PREG_W-1:0] ren_old_rd_phys,
    output logic                      ren_has_rd,
    input  logic                      free_valid,
    input  logic [`RENAME_PREG_W-1:0] free_preg
);
    // instruction queue wires
    logic          iq_push;
    logic          iq_pop;
    logic          iq_full;
    logic          iq_empty;
    decoded_inst_t iq_wdata;
    decoded_inst_t iq_rdata;

    // free list wires, full is never reached with 32 spare registers
    logic  fl_push;
    logic  fl_pop;
    logic  fl_empty;
    preg_t fl_wdata;
    preg_t fl_rdata;

    renamed_inst_t ren_inst;

    rat_if rat_bus ();

    wb_fetch u_fetch (
        .clk(clk), .rst(rst),
        .imem_adr(imem_adr), .imem_cyc(imem_cyc), .imem_stb(imem_stb),
        .imem_rdata(imem_rdata), .imem_ack(imem_ack),
        .iq_full(iq_full), .iq_push(iq_push), .iq_data(iq_wdata)
    );

    sync_fifo #(.payload_t(decoded_inst_t), .DEPTH(`RENAME_IQ_DEPTH)) u_iq (
        .clk(clk), .rst(rst),
        .push(iq_push), .wdata(iq_wdata), .pop(iq_pop), .rdata(iq_rdata),
        .full(iq_full), .empty(iq_empty)
    );

    sync_fifo #(.payload_t(preg_t), .DEPTH(`RENAME_PHYS_REGS)) u_free_list (
        .clk(clk), .rst(rst),
        .push(fl_push), .wdata(fl_wdata), .pop(fl_pop), .rdata(fl_rdata),
        .full(), .empty(fl_empty)
    );

    rename_stage u_rename (
        .clk(clk), .rst(rst),
        .iq_data(iq_rdata), .iq_empty(iq_empty), .iq_pop(iq_pop),
        .fl_data(fl_rdata), .fl_empty(fl_empty), .fl_pop(fl_pop),
        .fl_push(fl_push), .fl_wdata(fl_wdata),
        .rat_port(rat_bus.stage),
        .free_valid(free_valid), .free_preg(free_preg),
        .ren_valid(ren_valid), .ren_ready(ren_ready), .ren_inst(ren_inst)
    );

    rat u_rat (
        .clk(clk), .rst(rst),
        .rat_port(rat_bus.tbl)
    );

    // renamed struct split onto the flat output ports
    assign ren_pc          = ren_inst.pc;
    assign ren_instr       = ren_inst.instr;
    assign ren_rs1_phys    = ren_inst.rs1_phys;
    assign ren_rs2_phys    = ren_inst.rs2_phys;
    assign ren_rd_phys     = ren_inst.rd_phys;
    assign ren_old_rd_phys = ren_inst.old_rd_phys;
    assign ren_has_rd      = ren_inst.has_rd;
endmodule

// ==== hdl/rename_stage.sv ====
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_stage
    import rename_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  decoded_inst_t iq_data,
    input  logic          iq_empty,
    output logic          iq_pop,
    input  preg_t         fl_data,
    input  logic          fl_empty,
    output logic          fl_pop,
    output logic          fl_push,
    output preg_t         fl_wdata,
    rat_if.stage          rat_port,
    input  logic          free_valid,
    input  preg_t         free_preg,
    output logic          ren_valid,
    input  logic          ren_ready,
    output renamed_inst_t ren_inst
);
    // registers above the identity mapping start out free
    localparam preg_t FILL_FIRST = preg_t'(`RENAME_ARCH_REGS);
    localparam preg_t FILL_LAST  = preg_t'(`RENAME_PHYS_REGS - 1);

    logic  filling;
    preg_t fill_cnt;
    logic  out_free;

    // fill sequence, one register per cycle, 32 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            filling  <= 1'b1;
            fill_cnt <= FILL_FIRST;
        end else if (filling) begin
            if (fill_cnt == FILL_LAST) begin
                filling <= 1'b0;
            end else begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // free-list input, fill counter first, then retired registers
    assign fl_push  = filling || free_valid;
    assign fl_wdata = filling ? fill_cnt : free_preg;

    // output register empty or handing off this cycle
    assign out_free = !ren_valid || ren_ready;

    // stall when a destination is needed and none is free
    assign iq_pop = !filling && !iq_empty && out_free && (!iq_data.has_rd || !fl_empty);
    assign fl_pop = iq_pop && iq_data.has_rd;

    // alias table lookup and update
    assign rat_port.rs1_arch    = iq_data.rs1;
    assign rat_port.rs2_arch    = iq_data.rs2;
    assign rat_port.rd_arch     = iq_data.rd;
    assign rat_port.we          = fl_pop;
    assign rat_port.new_rd_phys = fl_data;

    // valid bit of the output register
    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= 1'b0;
        end else if (iq_pop) begin
            ren_valid <= 1'b1;
        end else if (ren_ready) begin
            ren_valid <= 1'b0;
        end
    end

    // payload loads only on a pop, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (iq_pop) begin
            ren_inst.pc       <= iq_data.pc;
            ren_inst.instr    <= iq_data.instr;
            ren_inst.rs1_phys <= rat_port.rs1_phys;
            ren_inst.rs2_phys <= rat_port.rs2_phys;
            // no destination shows as p0 in both fields
            ren_inst.rd_phys     <= iq_data.has_rd ? fl_data : '0;
            ren_inst.old_rd_phys <= iq_data.has_rd ? rat_port.old_rd_phys : '0;
            ren_inst.has_rd      <= iq_data.has_rd;
        end
    end

    // nothing has been allocated yet, so nothing can retire during fill
    a_no_free_in_fill: assert property (@(posedge clk) disable iff (rst)
        filling |-> !free_valid);
endmodule

// ==== hdl/rat.sv ====
`timescale 1ns/1ps
`include "rename_defines.svh"

module rat
    import rename_pkg::*;
(
    input logic clk,
    input logic rst,
    rat_if.tbl  rat_port
);
    // one physical index per architectural register
    preg_t map [`RENAME_ARCH_REGS];

    // lookups are combinational
    assign rat_port.rs1_phys    = map[rat_port.rs1_arch];
    assign rat_port.rs2_phys    = map[rat_port.rs2_arch];
    // mapping being replaced, read before the write lands
    assign rat_port.old_rd_phys = map[rat_port.rd_arch];

    // identity after reset, r lives in p r
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (rat_port.we) begin
            map[rat_port.rd_arch] <= rat_port.new_rd_phys;
        end
    end

    // x0 keeps its mapping to p0 for good
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        rat_port.we |-> (rat_port.rd_arch != '0));
endmodule

// ==== hdl/wb_fetch.sv ====
`timescale 1ns/1ps
`include "rename_defines.svh"

module wb_fetch
    import rename_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    output logic [`RENAME_XLEN-1:0] imem_adr,
    output logic                    imem_cyc,
    output logic                    imem_stb,
    input  logic [`RENAME_XLEN-1:0] imem_rdata,
    input  logic                    imem_ack,
    input  logic                    iq_full,
    output logic                    iq_push,
    output decoded_inst_t           iq_data
);
    // rv32i opcodes that write rd
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [`RENAME_XLEN-1:0] PC_STEP = 4;

    logic [`RENAME_XLEN-1:0] pc;
    logic                    req;
    logic                    writes_reg;

    // classic cycle, one beat, cyc and stb move together
    assign imem_adr = pc;
    assign imem_cyc = req;
    assign imem_stb = req;

    // word goes straight into the queue on the ack edge
    assign iq_push = req && imem_ack;

    // one request outstanding at most, so the queue cannot fill under it
    always_ff @(posedge clk) begin
        if (rst) begin
            pc  <= '0;
            req <= 1'b0;
        end else if (req) begin
            if (imem_ack) begin
                req <= 1'b0;
                pc  <= pc + PC_STEP;
            end
        end else if (!iq_full) begin
            req <= 1'b1;
        end
    end

    // branches, stores, fence and system write nothing
    always_comb begin
        case (imem_rdata[6:0])
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LOAD, OP_IMM, OP_REG: writes_reg = 1'b1;
            default:                 writes_reg = 1'b0;
        endcase
    end

    // register fields taken raw, whatever the format
    assign iq_data.pc     = pc;
    assign iq_data.instr  = imem_rdata;
    assign iq_data.rs1    = imem_rdata[19:15];
    assign iq_data.rs2    = imem_rdata[24:20];
    assign iq_data.rd     = imem_rdata[11:7];
    assign iq_data.has_rd = writes_reg && (imem_rdata[11:7] != '0);

    // a classic slave acks only inside an open cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        imem_ack |-> (imem_cyc && imem_stb));
endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     full,
    output logic     empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // head entry is always visible
    assign rdata = mem[rd_ptr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // storage array
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // producer and consumer sit in other modules and must honour the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);
endmodule

// ==== hdl/rat_if.sv ====
`timescale 1ns/1ps

interface rat_if
    import rename_pkg::*;
();
    // lookup side, arch indices in and phys indices back the same cycle
    areg_t rs1_arch;
    areg_t rs2_arch;
    areg_t rd_arch;
    preg_t rs1_phys;
    preg_t rs2_phys;
    preg_t old_rd_phys;

    // update side, new_rd_phys lands at rd_arch on the clock edge
    logic  we;
    preg_t new_rd_phys;

    modport stage (output rs1_arch, rs2_arch, rd_arch, we, new_rd_phys,
                   input  rs1_phys, rs2_phys, old_rd_phys);

    modport tbl   (input  rs1_arch, rs2_arch, rd_arch, we, new_rd_phys,
                   output rs1_phys, rs2_phys, old_rd_phys);
endinterface

// ==== hdl/rename_pkg.sv ====
`include "rename_defines.svh"

package rename_pkg;

    // register indices
    typedef logic [`RENAME_AREG_W-1:0] areg_t;
    typedef logic [`RENAME_PREG_W-1:0] preg_t;

    // fetched word with its register fields pulled out
    typedef struct packed {
        logic [`RENAME_XLEN-1:0] pc;
        logic [`RENAME_XLEN-1:0] instr;
        areg_t                   rs1;
        areg_t                   rs2;
        areg_t                   rd;
        // set only for a register-writing opcode with rd != x0
        logic                    has_rd;
    } decoded_inst_t;

    // instruction after mapping onto physical registers
    typedef struct packed {
        logic [`RENAME_XLEN-1:0] pc;
        logic [`RENAME_XLEN-1:0] instr;
        preg_t                   rs1_phys;
        preg_t                   rs2_phys;
        preg_t                   rd_phys;
        // mapping of rd before this instruction, released at retire
        preg_t                   old_rd_phys;
        logic                    has_rd;
    } renamed_inst_t;

endpackage

// ==== hdl/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// data and address width of the core
`define RENAME_XLEN 32

// register counts
`define RENAME_ARCH_REGS 32
`define RENAME_PHYS_REGS 64

// entries in the instruction queue
`define RENAME_IQ_DEPTH 8

// index widths, log2 of the register counts
`define RENAME_AREG_W 5
`define RENAME_PREG_W 6

`endif
